//--- design/adc_capture_config.svh
`ifndef ADC_CAPTURE_CONFIG_SVH
`define ADC_CAPTURE_CONFIG_SVH

// adc geometry, one channel per lane
`define ADC_LANES       8
`define ADC_BITS        24

// command stream
`define CMD_BYTES       4
`define CMD_PING        8'h01
`define CMD_CAPTURE     8'h02

// reply codes, sent as the first byte of every reply
`define RSP_PING        8'h50
`define RSP_FRAME       8'h43
`define RSP_NAK         8'h4E
`define RSP_MAX_BYTES   25      // seq byte plus eight 3-byte channels

`endif

//--- design/adc_capture_pkg.sv
`include "adc_capture_config.svh"

package adc_capture_pkg;

    // one byte of a command or reply stream
    typedef struct packed
    {
        logic [7:0] data;
        logic       last;
    } stream_beat_t;

    // capture arguments, bytes 1..3 of a command
    typedef struct packed
    {
        logic [7:0]  lane_mask;   // bit n selects lane n
        logic [15:0] frame_count;
    } capture_args_t;

    // same three bytes, read per opcode
    typedef union packed
    {
        capture_args_t cap;
        logic [23:0]   token;     // ping echo
    } cmd_args_u;

    typedef struct packed
    {
        logic [7:0] opcode;
        logic       malformed;    // packet ended before the fourth byte
        cmd_args_u  args;
    } cmd_t;

    // lane 0 sits in the lowest slot
    typedef logic [`ADC_LANES-1:0][`ADC_BITS-1:0] adc_frame_t;

    typedef struct packed
    {
        logic [7:0]                   code;
        logic [4:0]                   len;      // payload bytes after the code
        logic [`RSP_MAX_BYTES*8-1:0]  payload;  // first byte in the top bits
    } reply_t;

endpackage

//--- design/adc_tdm_deserializer.sv
`timescale 1ns/1ps
`include "adc_capture_config.svh"

module adc_tdm_deserializer
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fsync,
    input  logic                         dclk,
    input  logic [`ADC_LANES-1:0]        dout,
    output adc_capture_pkg::adc_frame_t  frame,
    output logic                         frame_valid
);
    import adc_capture_pkg::*;

    localparam int PIN_W = `ADC_LANES + 2;
    localparam int CNT_W = $clog2(`ADC_BITS);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`ADC_BITS - 1);

    logic [PIN_W-1:0]      pins_meta;
    logic [PIN_W-1:0]      pins_sync;
    logic                  fsync_s;
    logic                  dclk_s;
    logic [`ADC_LANES-1:0] dout_s;
    logic                  dclk_prev;
    logic                  dclk_rise;
    logic [CNT_W-1:0]      bit_cnt;     // bits collected so far, 0 when idle
    logic                  frame_done;
    adc_frame_t            shreg;
    adc_frame_t            shift_next;

    assign {fsync_s, dclk_s, dout_s} = pins_sync;
    assign dclk_rise = dclk_s && !dclk_prev;

    // 24th bit of a frame, unless a new fsync cuts it short
    assign frame_done = dclk_rise && !fsync_s && (bit_cnt == LAST_BIT);

    // all lanes shift together, msb first
    always_comb
    begin
        for (int l = 0; l < `ADC_LANES; l++)
        begin
            shift_next[l] = {shreg[l][`ADC_BITS-2:0], dout_s[l]};
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pins_meta   <= '0;
            pins_sync   <= '0;
            dclk_prev   <= 1'b0;
            bit_cnt     <= '0;
            frame_valid <= 1'b0;
        end
        else
        begin
            pins_meta   <= {fsync, dclk, dout};   // two-flop sync on all pins
            pins_sync   <= pins_meta;
            dclk_prev   <= dclk_s;
            frame_valid <= frame_done;
            if (dclk_rise)
            begin
                if (fsync_s)
                    bit_cnt <= CNT_W'(1);          // fsync edge carries bit 0
                else if (bit_cnt == LAST_BIT)
                    bit_cnt <= '0;
                else if (bit_cnt != '0)
                    bit_cnt <= bit_cnt + 1'b1;    // idle edges are ignored
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (dclk_rise)
            shreg <= shift_next;
        if (frame_done)
            frame <= shift_next;                  // latched copy for the sequencer
    end

endmodule

//--- design/cmd_decoder.sv
`timescale 1ns/1ps
`include "adc_capture_config.svh"

module cmd_decoder
(
    input  logic                          clk,
    input  logic                          rst,
    input  adc_capture_pkg::stream_beat_t s_beat,
    input  logic                          s_valid,
    output logic                          s_ready,
    output adc_capture_pkg::cmd_t         cmd,
    output logic                          cmd_valid,
    input  logic                          cmd_ready
);

    localparam int CNT_W = $clog2(`CMD_BYTES);
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`CMD_BYTES - 1);

    logic             take;
    logic             cmd_done;
    logic             cmd_valid_n;
    logic [CNT_W-1:0] byte_cnt;
    logic             skip;          // dropping the tail of a long packet

    assign take = s_valid && s_ready;

    // fourth byte, or an early last
    assign cmd_done = take && !skip && ((byte_cnt == LAST_IDX) || s_beat.last);

    assign cmd_valid_n = cmd_done || (cmd_valid && !cmd_ready);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cmd_valid <= 1'b0;
            s_ready   <= 1'b0;
            byte_cnt  <= '0;
            skip      <= 1'b0;
        end
        else
        begin
            cmd_valid <= cmd_valid_n;
            s_ready   <= !cmd_valid_n;     // closed while a command is held
            if (take)
            begin
                if (skip)
                begin
                    skip <= !s_beat.last;
                end
                else if (cmd_done)
                begin
                    byte_cnt <= '0;
                    skip     <= (byte_cnt == LAST_IDX) && !s_beat.last;
                end
                else
                begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    // command contents
    always_ff @(posedge clk)
    begin
        if (take && !skip)
        begin
            if (byte_cnt == '0)
            begin
                cmd.opcode     <= s_beat.data;
                cmd.args.token <= '0;       // short packets leave zeros
            end
            else
            begin
                cmd.args.token[(`CMD_BYTES - 1 - byte_cnt) * 8 +: 8] <= s_beat.data;
            end
            if (cmd_done)
                cmd.malformed <= (byte_cnt != LAST_IDX);
        end
    end

endmodule

//--- design/capture_sequencer.sv
`timescale 1ns/1ps
`include "adc_capture_config.svh"

module capture_sequencer
(
    input  logic                        clk,
    input  logic                        rst,
    input  adc_capture_pkg::cmd_t       cmd,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    input  adc_capture_pkg::adc_frame_t frame,
    input  logic                        frame_valid,
    output adc_capture_pkg::reply_t     reply,
    output logic                        reply_valid,
    input  logic                        reply_ready
);

    localparam int PAY_W = `RSP_MAX_BYTES * 8;
    localparam logic [4:0] CH_BYTES = 5'(`ADC_BITS / 8);

    typedef enum logic
    {
        S_IDLE,
        S_CAPTURE
    } state_t;

    state_t          state;
    logic            cmd_take;
    logic            frame_take;
    logic            op_ping;
    logic            op_capture;
    logic            cmd_bad;
    logic [7:0]      mask_q;
    logic [15:0]     frames_left;
    logic [7:0]      seq;
    logic [PAY_W-1:0] frame_payload;
    logic [4:0]      frame_len;

    assign cmd_ready  = (state == S_IDLE) && !reply_valid;
    assign cmd_take   = cmd_valid && cmd_ready;
    assign frame_take = (state == S_CAPTURE) && frame_valid && !reply_valid;  // else dropped

    assign op_ping    = (cmd.opcode == `CMD_PING);
    assign op_capture = (cmd.opcode == `CMD_CAPTURE);
    assign cmd_bad    = cmd.malformed || !(op_ping || op_capture) ||
                        (op_capture && ((cmd.args.cap.lane_mask == '0) ||
                                        (cmd.args.cap.frame_count == '0)));

    // seq byte, then selected lanes packed upward
    always_comb
    begin
        frame_payload = '0;
        frame_payload[PAY_W-1 -: 8] = seq;
        frame_len = 5'd1;
        for (int l = 0; l < `ADC_LANES; l++)
        begin
            if (mask_q[l])
            begin
                frame_payload[PAY_W - 1 - frame_len * 8 -: `ADC_BITS] = frame[l];
                frame_len = frame_len + CH_BYTES;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= S_IDLE;
            reply_valid <= 1'b0;
            frames_left <= '0;
            seq         <= '0;
        end
        else
        begin
            if (reply_valid && reply_ready)
                reply_valid <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (cmd_take)
                    begin
                        if (cmd_bad || op_ping)
                        begin
                            reply_valid <= 1'b1;
                        end
                        else
                        begin
                            frames_left <= cmd.args.cap.frame_count;
                            seq         <= '0;
                            state       <= S_CAPTURE;
                        end
                    end
                end
                S_CAPTURE:
                begin
                    if (frame_take)
                    begin
                        reply_valid <= 1'b1;
                        seq         <= seq + 1'b1;
                        frames_left <= frames_left - 1'b1;
                        if (frames_left == 16'd1)
                            state <= S_IDLE;    // last frame of the request
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // reply record and capture mask
    always_ff @(posedge clk)
    begin
        if (cmd_take && cmd_bad)
        begin
            reply.code    <= `RSP_NAK;
            reply.len     <= 5'd1;
            reply.payload <= {cmd.opcode, {(PAY_W - 8){1'b0}}};
        end
        else if (cmd_take && op_ping)
        begin
            reply.code    <= `RSP_PING;
            reply.len     <= 5'd3;
            reply.payload <= {cmd.args.token, {(PAY_W - 24){1'b0}}};
        end
        else if (frame_take)
        begin
            reply.code    <= `RSP_FRAME;
            reply.len     <= frame_len;
            reply.payload <= frame_payload;
        end
        if (cmd_take && !cmd_bad && op_capture)
            mask_q <= cmd.args.cap.lane_mask;
    end

endmodule

//--- design/reply_serializer.sv
`timescale 1ns/1ps
`include "adc_capture_config.svh"

module reply_serializer
(
    input  logic                          clk,
    input  logic                          rst,
    input  adc_capture_pkg::reply_t       reply,
    input  logic                          reply_valid,
    output logic                          reply_ready,
    output adc_capture_pkg::stream_beat_t m_beat,
    output logic                          m_valid,
    input  logic                          m_ready
);

    // code byte sits above the payload
    localparam int SH_W = (`RSP_MAX_BYTES + 1) * 8;

    logic [SH_W-1:0] shreg;
    logic [4:0]      remaining;    // bytes left including the one on the bus
    logic            load;
    logic            beat_done;

    assign reply_ready = !m_valid;  // one record at a time
    assign load        = reply_valid && reply_ready;
    assign beat_done   = m_valid && m_ready;

    assign m_beat = '{data: shreg[SH_W-1 -: 8], last: (remaining == 5'd1)};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            m_valid   <= 1'b0;
            remaining <= '0;
        end
        else if (load)
        begin
            m_valid   <= 1'b1;
            remaining <= reply.len + 5'd1;
        end
        else if (beat_done)
        begin
            if (remaining == 5'd1)
                m_valid <= 1'b0;          // final byte went out
            remaining <= remaining - 5'd1;
        end
    end

    // beat held as is until it transfers
    always_ff @(posedge clk)
    begin
        if (load)
            shreg <= {reply.code, reply.payload};
        else if (beat_done)
            shreg <= shreg << 8;
    end

endmodule

//--- design/adc_capture_top.sv
`timescale 1ns/1ps
`include "adc_capture_config.svh"

module adc_capture_top
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fsync,
    input  logic                          dclk,
    input  logic [`ADC_LANES-1:0]         dout,
    input  adc_capture_pkg::stream_beat_t s_beat,
    input  logic                          s_valid,
    output logic                          s_ready,
    output adc_capture_pkg::stream_beat_t m_beat,
    output logic                          m_valid,
    input  logic                          m_ready
);
    import adc_capture_pkg::*;

    adc_frame_t frame;
    logic       frame_valid;    // single-cycle pulse, no back-pressure
    cmd_t       cmd;
    logic       cmd_valid;
    logic       cmd_ready;
    reply_t     reply;
    logic       reply_valid;
    logic       reply_ready;

    adc_tdm_deserializer u_deser
    (
        .clk         (clk),
        .rst         (rst),
        .fsync       (fsync),
        .dclk        (dclk),
        .dout        (dout),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    cmd_decoder u_decoder
    (
        .clk       (clk),
        .rst       (rst),
        .s_beat    (s_beat),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready)
    );

    capture_sequencer u_sequencer
    (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .frame       (frame),
        .frame_valid (frame_valid),
        .reply       (reply),
        .reply_valid (reply_valid),
        .reply_ready (reply_ready)
    );

    reply_serializer u_serializer
    (
        .clk         (clk),
        .rst         (rst),
        .reply       (reply),
        .reply_valid (reply_valid),
        .reply_ready (reply_ready),
        .m_beat      (m_beat),
        .m_valid     (m_valid),
        .m_ready     (m_ready)
    );

endmodule

//--- verif/adc_capture_chk.sv
`timescale 1ns/1ps

module adc_capture_chk
(
    input logic                          clk,
    input logic                          rst,
    input logic                          s_ready,
    input adc_capture_pkg::stream_beat_t m_beat,
    input logic                          m_valid,
    input logic                          m_ready
);

    // stalled beat keeps data and last
    beat_held: assert property (@(posedge clk) disable iff (rst)
        (m_valid && !m_ready) |=> $stable(m_beat))
        else $error("m_beat changed while stalled");

    reset_quiet: assert property (@(posedge clk)
        rst |=> (!s_ready && !m_valid))
        else $error("stream handshake active during reset");

    valid_held: assert property (@(posedge clk) disable iff (rst)
        (m_valid && !m_ready) |=> m_valid)
        else $error("m_valid dropped before its beat transferred");

endmodule

bind adc_capture_top adc_capture_chk u_chk
(
    .clk     (clk),
    .rst     (rst),
    .s_ready (s_ready),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready)
);

//--- verif/adc_capture_tb.sv
`timescale 1ns/1ps
`include "adc_capture_config.svh"

module adc_capture_tb;
    import adc_capture_pkg::*;

    localparam int NUM_TESTS = 7;

    typedef struct packed
    {
        logic [47:0] bytes;       // command bytes, first one in the top bits
        logic [2:0]  nbytes;
        logic        rand_ready;  // random back-pressure on m_ready
        logic [3:0]  frames;      // adc frames to generate
        logic [7:0]  code;        // expected reply code
    } test_row_t;

    logic                  clk = 1'b0;
    logic                  rst = 1'b1;
    logic                  fsync;
    logic                  dclk;
    logic [`ADC_LANES-1:0] dout;
    stream_beat_t          s_beat;
    logic                  s_valid;
    logic                  s_ready;
    stream_beat_t          m_beat;
    logic                  m_valid;
    logic                  m_ready = 1'b0;

    test_row_t    tests [NUM_TESTS];
    stream_beat_t exp_q [$];
    stream_beat_t rx_q [$];
    logic [7:0]   cur [$];      // one reply being built
    logic         rand_ready = 1'b0;
    logic [31:0]  ready_rnd;
    int           seed = 32'h58ad;
    int           ready_seed = 32'h58ad;
    int           value_errs = 0;
    int           last_errs = 0;
    int           proto_errs = 0;
    int           cycle_cnt = 0;
    int           cycle_limit = 0;
    int           row = 0;

    always #2 clk = ~clk;

    adc_capture_top uut
    (
        .clk     (clk),
        .rst     (rst),
        .fsync   (fsync),
        .dclk    (dclk),
        .dout    (dout),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    // back-pressure and reply capture, both on the falling edge
    always @(negedge clk)
    begin
        ready_rnd = $random(ready_seed);
        m_ready = rand_ready ? ready_rnd[0] : 1'b1;
        if (m_valid && m_ready)
            rx_q.push_back(m_beat);     // transfers at the next rising edge
    end

    initial
    begin
        @(posedge clk);
        while (cycle_cnt < cycle_limit)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: replies still missing after %0d cycles", cycle_cnt);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // moves the reply in cur to the expected stream, last on its final byte
    task automatic push_expected();
        begin
            for (int i = 0; i < cur.size(); i++)
                exp_q.push_back('{data: cur[i], last: (i == cur.size() - 1)});
            cur.delete();
        end
    endtask

    task automatic send_byte(input logic [7:0] data, input logic is_last);
        begin
            s_beat = '{data: data, last: is_last};
            s_valid = 1'b1;
            while (s_ready !== 1'b1)
                @(negedge clk);
            @(negedge clk);                 // taken at the rising edge just passed
            s_valid = 1'b0;
        end
    endtask

    // one frame on the pins, dclk at 8 clk per bit, data set while dclk is low
    task automatic drive_frame(input logic [7:0] seqn, input logic [7:0] mask);
        logic [`ADC_BITS-1:0] pkt [`ADC_LANES];
        begin
            cur.push_back(`RSP_FRAME);
            cur.push_back(seqn);
            for (int l = 0; l < `ADC_LANES; l++)
            begin
                pkt[l] = 24'($random(seed));
                if (mask[l])
                begin
                    cur.push_back(pkt[l][23:16]);
                    cur.push_back(pkt[l][15:8]);
                    cur.push_back(pkt[l][7:0]);
                end
            end
            push_expected();
            for (int b = 0; b < `ADC_BITS; b++)
            begin
                fsync = (b == 0);
                for (int l = 0; l < `ADC_LANES; l++)
                    dout[l] = pkt[l][`ADC_BITS - 1 - b];
                dclk = 1'b0;
                repeat (4) @(negedge clk);
                dclk = 1'b1;
                repeat (4) @(negedge clk);
            end
            dclk = 1'b0;
            fsync = 1'b0;
        end
    endtask

    task automatic check_replies();
        int n;
        begin
            n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
            if (rx_q.size() != exp_q.size())
            begin
                $display("row %0d: reply stream carried %0d bytes where %0d were expected",
                         row, rx_q.size(), exp_q.size());
                proto_errs++;
            end
            for (int i = 0; i < n; i++)
            begin
                if (rx_q[i].data !== exp_q[i].data)
                begin
                    $display("** Error: m_beat.data row %0d byte %0d got 0x%h expected 0x%h",
                             row, i, rx_q[i].data, exp_q[i].data);
                    value_errs++;
                end
                if (rx_q[i].last !== exp_q[i].last)
                begin
                    $display("** Error: m_beat.last row %0d byte %0d got 0x%h expected 0x%h",
                             row, i, rx_q[i].last, exp_q[i].last);
                    last_errs++;
                end
            end
            rx_q.delete();
            exp_q.delete();
        end
    endtask

    // entered and left on a rising edge
    task automatic run_row(input test_row_t t);
        begin
            rand_ready = t.rand_ready;
            if (t.code == `RSP_NAK)
            begin
                cur.push_back(`RSP_NAK);
                cur.push_back(t.bytes[47:40]);     // opcode echoed
                push_expected();
            end
            else if (t.code == `RSP_PING)
            begin
                cur.push_back(`RSP_PING);
                for (int i = 1; i < `CMD_BYTES; i++)
                    cur.push_back(t.bytes[47 - 8 * i -: 8]);
                push_expected();
            end
            @(negedge clk);
            for (int i = 0; i < int'(t.nbytes); i++)
                send_byte(t.bytes[47 - 8 * i -: 8], i == int'(t.nbytes) - 1);
            repeat (20) @(negedge clk);
            for (int f = 0; f < int'(t.frames); f++)
                drive_frame(8'(f), t.bytes[39:32]);
            @(posedge clk);
            while (rx_q.size() < exp_q.size())
                @(posedge clk);
            repeat (30) @(posedge clk);        // room for any extra reply
            check_replies();
        end
    endtask

    initial
    begin
        fsync   = 1'b0;
        dclk    = 1'b0;
        dout    = '0;
        s_beat  = '0;
        s_valid = 1'b0;

        // bytes, count, random ready, frames, reply code
        tests[0] = '{48'h01_12_34_56_00_00, 3'd4, 1'b1, 4'd0, `RSP_PING};
        tests[1] = '{48'h02_A5_00_03_00_00, 3'd4, 1'b1, 4'd3, `RSP_FRAME};
        tests[2] = '{48'h01_99_00_00_00_00, 3'd2, 1'b0, 4'd0, `RSP_NAK};  // short packet
        tests[3] = '{48'h7F_00_00_00_00_00, 3'd4, 1'b0, 4'd0, `RSP_NAK};
        tests[4] = '{48'h02_00_00_05_00_00, 3'd4, 1'b0, 4'd0, `RSP_NAK};  // zero mask
        tests[5] = '{48'h01_AB_CD_EF_11_22, 3'd6, 1'b0, 4'd0, `RSP_PING}; // long packet
        tests[6] = '{48'h02_FF_00_01_00_00, 3'd4, 1'b0, 4'd1, `RSP_FRAME};

        for (int i = 0; i < NUM_TESTS; i++)
            cycle_limit += (1 + int'(tests[i].frames)) * 400;

        repeat (5) @(negedge clk);
        rst = 1'b0;
        repeat (20)
        begin
            @(negedge clk);
            if (m_valid !== 1'b0)
            begin
                $display("m_valid went high with no command sent");
                proto_errs++;
            end
        end
        if (s_ready !== 1'b1)
        begin
            $display("** Error: s_ready got 0x%h expected 0x1", s_ready);
            value_errs++;
        end

        @(posedge clk);
        for (row = 0; row < NUM_TESTS; row++)
            run_row(tests[row]);

        $display("errors: value %0d, last %0d, protocol %0d", value_errs, last_errs, proto_errs);
        if (value_errs + last_errs + proto_errs == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- flist.f
+incdir+design
design/adc_capture_pkg.sv
design/adc_tdm_deserializer.sv
design/cmd_decoder.sv
design/capture_sequencer.sv
design/reply_serializer.sv
design/adc_capture_top.sv
verif/adc_capture_chk.sv
verif/adc_capture_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module adc_capture_tb -o adc_capture_sim

./obj_dir/adc_capture_sim | tee sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
